//--- common/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// **************************************************
// datapath
// **************************************************

`define DATA_W   32
`define ALU_OP_W 8

// **************************************************
// integer operation codes
// **************************************************

`define ALU_ADD  8'h01
`define ALU_SUB  8'h02
`define ALU_AND  8'h03
`define ALU_OR   8'h04
`define ALU_XOR  8'h05
`define ALU_SLT  8'h06
`define ALU_SLTU 8'h07
`define ALU_SLL  8'h08
`define ALU_SRL  8'h09
`define ALU_SRA  8'h0a

// **************************************************
// branch operation codes
// **************************************************

`define ALU_BEQ  8'h20
`define ALU_BNE  8'h21
`define ALU_BLT  8'h22
`define ALU_BGE  8'h23
`define ALU_BLTU 8'h24
`define ALU_BGEU 8'h25
`define ALU_B    8'h26
`define ALU_BL   8'h27
`define ALU_JIRL 8'h28

// any other code is a no-op with result 0

`endif

//--- common/pipeline_pkg.sv
`include "core_params.svh"

package pipeline_pkg;

    // generic word: pc, instruction, operands, results, addresses
    typedef logic [`DATA_W-1:0] bus32_t;

    typedef logic [`ALU_OP_W-1:0] alu_op_t;

    // **************************************************
    // predictor update record
    // **************************************************

    typedef struct packed {
        logic   update_en;
        logic   taken_or_not_actual;
        logic   branch_flush;
        bus32_t branch_actual_addr;
        // pc of the branch, indexes the predictor tables
        bus32_t pc_dispatch;
    } branch_update;

    // **************************************************
    // commit handshake states
    // **************************************************

    typedef enum logic [1:0] {
        IDLE,
        HOLD_IN_ACK,
        PRESENT,
        WAIT_ACK_LOW
    } commit_state_t;

endpackage

//--- common/exe_result_if.sv
interface exe_result_if
    import pipeline_pkg::*;
();

    // unit claims the current operation
    logic         valid;

    bus32_t       result;

    // zero for units that do not resolve branches
    branch_update upd;

    modport unit (
        output valid,
        output result,
        output upd
    );

    modport commit (
        input valid,
        input result,
        input upd
    );

endinterface

//--- branch_alu/branch_alu.sv
`include "core_params.svh"

module branch_alu
    import pipeline_pkg::*;
(
    input bus32_t  pc,
    input bus32_t  inst,
    input alu_op_t aluop,

    input bus32_t reg1,
    input bus32_t reg2,

    input logic   pre_is_branch_taken,
    input bus32_t pre_branch_addr,

    exe_result_if.unit res
);

    // **************************************************
    // operand compare
    // **************************************************

    logic reg1_eq_reg2;
    logic reg1_lt_reg2;
    logic reg1_ltu_reg2;

    assign reg1_eq_reg2  = (reg1 == reg2);
    assign reg1_lt_reg2  = ($signed(reg1) < $signed(reg2));
    assign reg1_ltu_reg2 = (reg1 < reg2);

    // **************************************************
    // offsets and targets
    // **************************************************

    bus32_t off16;
    bus32_t off26;
    bus32_t pc_plus4;

    // offs16 in inst[25:10], offs26 split as inst[9:0]:inst[25:10]
    assign off16    = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign off26    = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    assign pc_plus4 = pc + 32'h4;

    logic   is_branch;
    logic   is_taken;
    bus32_t target_addr;
    bus32_t link_value;

    always_comb begin : decode
        is_branch   = 1'b1;
        is_taken    = 1'b0;
        target_addr = pc + off16;
        link_value  = '0;
        case (aluop)
            `ALU_BEQ:  is_taken = reg1_eq_reg2;
            `ALU_BNE:  is_taken = !reg1_eq_reg2;
            `ALU_BLT:  is_taken = reg1_lt_reg2;
            `ALU_BGE:  is_taken = !reg1_lt_reg2;
            `ALU_BLTU: is_taken = reg1_ltu_reg2;
            `ALU_BGEU: is_taken = !reg1_ltu_reg2;
            `ALU_B: begin
                is_taken    = 1'b1;
                target_addr = pc + off26;
            end
            `ALU_BL: begin
                is_taken    = 1'b1;
                target_addr = pc + off26;
                link_value  = pc_plus4;
            end
            `ALU_JIRL: begin
                // register-relative target
                is_taken    = 1'b1;
                target_addr = reg1 + off16;
                link_value  = pc_plus4;
            end
            default: begin
                is_branch   = 1'b0;
                target_addr = '0;
            end
        endcase
    end

    // **************************************************
    // resolve against prediction
    // **************************************************

    branch_update upd;

    always_comb begin : resolve
        upd = '0;
        if (is_branch) begin
            upd.update_en           = 1'b1;
            upd.taken_or_not_actual = is_taken;
            upd.pc_dispatch         = pc;
            // wrong direction, or right direction but wrong target
            upd.branch_flush = (is_taken != pre_is_branch_taken)
                             || (is_taken && (pre_branch_addr != target_addr));
            if (is_taken) begin
                upd.branch_actual_addr = target_addr;
            end else if (pre_is_branch_taken) begin
                upd.branch_actual_addr = pc_plus4;
            end
        end
    end

    assign res.valid  = is_branch;
    assign res.result = link_value;
    assign res.upd    = upd;

endmodule

//--- src/int_alu.sv
`include "core_params.svh"

module int_alu
    import pipeline_pkg::*;
(
    input alu_op_t aluop,
    input bus32_t  reg1,
    input bus32_t  reg2,

    exe_result_if.unit res
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    bus32_t     alu_out;
    logic       is_int_op;

    assign shamt       = reg2[4:0];
    assign lt_signed   = ($signed(reg1) < $signed(reg2));
    assign lt_unsigned = (reg1 < reg2);

    // **************************************************
    // operation select
    // **************************************************

    always_comb begin : compute
        is_int_op = 1'b1;
        alu_out   = '0;
        case (aluop)
            `ALU_ADD:  alu_out = reg1 + reg2;
            `ALU_SUB:  alu_out = reg1 - reg2;
            `ALU_AND:  alu_out = reg1 & reg2;
            `ALU_OR:   alu_out = reg1 | reg2;
            `ALU_XOR:  alu_out = reg1 ^ reg2;
            `ALU_SLT:  alu_out = {{(`DATA_W-1){1'b0}}, lt_signed};
            `ALU_SLTU: alu_out = {{(`DATA_W-1){1'b0}}, lt_unsigned};
            `ALU_SLL:  alu_out = reg1 << shamt;
            `ALU_SRL:  alu_out = reg1 >> shamt;
            `ALU_SRA:  alu_out = bus32_t'($signed(reg1) >>> shamt);
            // branches and unused codes are not ours
            default:   is_int_op = 1'b0;
        endcase
    end

    assign res.valid  = is_int_op;
    assign res.result = alu_out;

    // no branch resolution here
    assign res.upd = '0;

endmodule

//--- src/exe_commit.sv
module exe_commit
    import pipeline_pkg::*;
(
    input logic clk,
    input logic arst_n,

    // issue side
    input  logic    in_req,
    input  bus32_t  in_pc,
    input  bus32_t  in_inst,
    input  alu_op_t in_aluop,
    input  bus32_t  in_reg1,
    input  bus32_t  in_reg2,
    input  logic    in_pre_taken,
    input  bus32_t  in_pre_addr,
    output logic    in_ack,

    // captured bundle into the units
    output bus32_t  cur_pc,
    output bus32_t  cur_inst,
    output alu_op_t cur_aluop,
    output bus32_t  cur_reg1,
    output bus32_t  cur_reg2,
    output logic    cur_pre_taken,
    output bus32_t  cur_pre_addr,

    exe_result_if.commit int_res,
    exe_result_if.commit br_res,

    // writeback side
    input  logic   wb_ack,
    output logic   wb_req,
    output bus32_t wb_pc,
    output bus32_t wb_data,
    output logic   redirect,
    output bus32_t redirect_addr,
    output logic   upd_en,
    output logic   upd_taken
);

    commit_state_t state;
    commit_state_t next_state;
    logic          capture_en;
    logic          present_en;
    bus32_t        comb_data;

    // **************************************************
    // handshake FSM
    // **************************************************

    always_comb begin
        next_state = state;
        case (state)
            IDLE:         if (in_req)  next_state = HOLD_IN_ACK;
            HOLD_IN_ACK:  if (!in_req) next_state = PRESENT;
            PRESENT:      if (wb_ack)  next_state = WAIT_ACK_LOW;
            WAIT_ACK_LOW: if (!wb_ack) next_state = IDLE;
            default:      next_state = IDLE;
        endcase
    end

    assign capture_en = (state == IDLE) && in_req;
    assign present_en = (state == HOLD_IN_ACK) && !in_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            in_ack <= 1'b0;
            wb_req <= 1'b0;
        end else begin
            state  <= next_state;
            in_ack <= (next_state == HOLD_IN_ACK);
            wb_req <= (next_state == PRESENT);
        end
    end

    // input register
    always_ff @(posedge clk) begin
        if (capture_en) begin
            cur_pc        <= in_pc;
            cur_inst      <= in_inst;
            cur_aluop     <= in_aluop;
            cur_reg1      <= in_reg1;
            cur_reg2      <= in_reg2;
            cur_pre_taken <= in_pre_taken;
            cur_pre_addr  <= in_pre_addr;
        end
    end

    // **************************************************
    // result combine and output register
    // **************************************************

    assign comb_data = int_res.valid ? int_res.result :
                       br_res.valid  ? br_res.result  : '0;

    always_ff @(posedge clk) begin
        if (present_en) begin
            wb_pc         <= cur_pc;
            wb_data       <= comb_data;
            redirect_addr <= br_res.upd.branch_actual_addr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            redirect  <= 1'b0;
            upd_en    <= 1'b0;
            upd_taken <= 1'b0;
        end else if (present_en) begin
            redirect  <= br_res.upd.branch_flush;
            upd_en    <= br_res.upd.update_en;
            upd_taken <= br_res.upd.taken_or_not_actual;
        end
    end

    // **************************************************
    // checks
    // **************************************************

    a_wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_req && !wb_ack) |=> ($stable(wb_data) && $stable(redirect)))
        else $error("exe_commit: writeback payload changed before wb_ack");

    // decode ranges of the two units must not overlap
    a_single_claim: assert property (@(posedge clk) disable iff (!arst_n)
        !(int_res.valid && br_res.valid))
        else $error("exe_commit: both units claim the operation");

endmodule

//--- src/exe_stage.sv
module exe_stage
    import pipeline_pkg::*;
(
    input logic clk,
    input logic arst_n,

    input  logic    in_req,
    input  bus32_t  in_pc,
    input  bus32_t  in_inst,
    input  alu_op_t in_aluop,
    input  bus32_t  in_reg1,
    input  bus32_t  in_reg2,
    input  logic    in_pre_taken,
    input  bus32_t  in_pre_addr,
    output logic    in_ack,

    input  logic   wb_ack,
    output logic   wb_req,
    output bus32_t wb_pc,
    output bus32_t wb_data,
    output logic   redirect,
    output bus32_t redirect_addr,
    output logic   upd_en,
    output logic   upd_taken
);

    // captured operation, shared by both units
    bus32_t  cur_pc;
    bus32_t  cur_inst;
    alu_op_t cur_aluop;
    bus32_t  cur_reg1;
    bus32_t  cur_reg2;
    logic    cur_pre_taken;
    bus32_t  cur_pre_addr;

    exe_result_if int_if ();
    exe_result_if br_if ();

    // **************************************************
    // execution units
    // **************************************************

    int_alu u_int_alu (
        .aluop (cur_aluop),
        .reg1  (cur_reg1),
        .reg2  (cur_reg2),
        .res   (int_if.unit)
    );

    branch_alu u_branch_alu (
        .pc                  (cur_pc),
        .inst                (cur_inst),
        .aluop               (cur_aluop),
        .reg1                (cur_reg1),
        .reg2                (cur_reg2),
        .pre_is_branch_taken (cur_pre_taken),
        .pre_branch_addr     (cur_pre_addr),
        .res                 (br_if.unit)
    );

    // **************************************************
    // commit
    // **************************************************

    exe_commit u_exe_commit (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_req        (in_req),
        .in_pc         (in_pc),
        .in_inst       (in_inst),
        .in_aluop      (in_aluop),
        .in_reg1       (in_reg1),
        .in_reg2       (in_reg2),
        .in_pre_taken  (in_pre_taken),
        .in_pre_addr   (in_pre_addr),
        .in_ack        (in_ack),
        .cur_pc        (cur_pc),
        .cur_inst      (cur_inst),
        .cur_aluop     (cur_aluop),
        .cur_reg1      (cur_reg1),
        .cur_reg2      (cur_reg2),
        .cur_pre_taken (cur_pre_taken),
        .cur_pre_addr  (cur_pre_addr),
        .int_res       (int_if.commit),
        .br_res        (br_if.commit),
        .wb_ack        (wb_ack),
        .wb_req        (wb_req),
        .wb_pc         (wb_pc),
        .wb_data       (wb_data),
        .redirect      (redirect),
        .redirect_addr (redirect_addr),
        .upd_en        (upd_en),
        .upd_taken     (upd_taken)
    );

endmodule

//--- bench/tb_exe_stage.sv
`include "core_params.svh"

module tb_exe_stage
    import pipeline_pkg::*;
();

    logic    clk;
    logic    arst_n;
    logic    in_req;
    bus32_t  in_pc;
    bus32_t  in_inst;
    alu_op_t in_aluop;
    bus32_t  in_reg1;
    bus32_t  in_reg2;
    logic    in_pre_taken;
    bus32_t  in_pre_addr;
    logic    in_ack;
    logic    wb_ack;
    logic    wb_req;
    bus32_t  wb_pc;
    bus32_t  wb_data;
    logic    redirect;
    bus32_t  redirect_addr;
    logic    upd_en;
    logic    upd_taken;

    // expected values for the operation in flight
    bus32_t exp_pc;
    bus32_t exp_data;
    logic   exp_redirect;
    bus32_t exp_addr;
    logic   exp_addr_valid;
    logic   exp_upd_en;
    logic   exp_taken;

    int value_errors;
    int protocol_errors;

    // a handshake timed out, later waits give up at once
    logic stalled;

    alu_op_t int_ops[10] = '{`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_XOR,
                             `ALU_SLT, `ALU_SLTU, `ALU_SLL, `ALU_SRL, `ALU_SRA};
    alu_op_t cond_ops[6] = '{`ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU};
    alu_op_t jump_ops[3] = '{`ALU_B, `ALU_BL, `ALU_JIRL};
    alu_op_t unused_ops[4] = '{8'h00, 8'h11, 8'h30, 8'hff};

    exe_stage DUT (.*);

    always #20 clk = ~clk;

    // **************************************************
    // reporting
    // **************************************************

    task automatic report_mismatch(input string name, input bus32_t exp, input bus32_t act);
        $display("FAIL %s expected %h actual %h", name, exp, act);
        value_errors++;
    endtask

    task automatic report_protocol(input string what);
        $display("protocol error: %s", what);
        protocol_errors++;
    endtask

    task automatic finish_run();
        $display("error counts: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    task automatic report_stall(input string what);
        if (!stalled) begin
            report_protocol({what, " handshake stalled for 200 cycles"});
        end
        stalled = 1'b1;
    endtask

    // **************************************************
    // checks on the writeback side
    // **************************************************

    a_pc: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_req) |-> wb_pc == exp_pc)
        else report_mismatch("wb_pc", exp_pc, wb_pc);
    a_data: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_req) |-> wb_data == exp_data)
        else report_mismatch("wb_data", exp_data, wb_data);
    a_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_req) |-> redirect == exp_redirect)
        else report_mismatch("redirect", exp_redirect, redirect);
    a_redirect_addr: assert property (@(posedge clk) disable iff (!arst_n)
        ($rose(wb_req) && exp_addr_valid) |-> redirect_addr == exp_addr)
        else report_mismatch("redirect_addr", exp_addr, redirect_addr);
    a_upd_en: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_req) |-> upd_en == exp_upd_en)
        else report_mismatch("upd_en", exp_upd_en, upd_en);
    a_upd_taken: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wb_req) |-> upd_taken == exp_taken)
        else report_mismatch("upd_taken", exp_taken, upd_taken);

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req))
        else report_protocol("in_ack rose without in_req");
    a_present_delay: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(in_req) |=> $rose(wb_req))
        else report_protocol("wb_req did not rise one cycle after in_req fell");
    a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_req && !wb_ack) |=> ($stable(wb_pc) && $stable(wb_data) && $stable(redirect)
                                 && $stable(redirect_addr) && $stable(upd_en)
                                 && $stable(upd_taken)))
        else report_protocol("writeback outputs changed while waiting for wb_ack");

    // **************************************************
    // reference model
    // **************************************************

    function automatic bus32_t branch_target(input alu_op_t op, input bus32_t pc,
                                             input bus32_t reg1, input int off);
        bus32_t base;
        base = (op == `ALU_JIRL) ? reg1 : pc;
        return base + bus32_t'(off * 4);
    endfunction

    // offs16 in [25:10], offs26 high part in [9:0]
    function automatic bus32_t make_inst(input alu_op_t op, input int off);
        bus32_t inst;
        inst        = $urandom();
        inst[25:10] = off[15:0];
        if (op == `ALU_B || op == `ALU_BL) begin
            inst[9:0] = off[25:16];
        end
        return inst;
    endfunction

    task automatic predict(input alu_op_t op, input bus32_t pc, input bus32_t reg1,
                           input bus32_t reg2, input logic pre_t, input bus32_t pre_a,
                           input int off);
        logic   is_br;
        logic   taken;
        bus32_t target;
        target = branch_target(op, pc, reg1, off);
        is_br  = op inside {`ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU,
                            `ALU_B, `ALU_BL, `ALU_JIRL};
        case (op)
            `ALU_ADD:  exp_data = reg1 + reg2;
            `ALU_SUB:  exp_data = reg1 - reg2;
            `ALU_AND:  exp_data = reg1 & reg2;
            `ALU_OR:   exp_data = reg1 | reg2;
            `ALU_XOR:  exp_data = reg1 ^ reg2;
            `ALU_SLT:  exp_data = ($signed(reg1) < $signed(reg2)) ? 32'd1 : 32'd0;
            `ALU_SLTU: exp_data = (reg1 < reg2) ? 32'd1 : 32'd0;
            `ALU_SLL:  exp_data = reg1 << reg2[4:0];
            `ALU_SRL:  exp_data = reg1 >> reg2[4:0];
            `ALU_SRA:  exp_data = $signed(reg1) >>> reg2[4:0];
            `ALU_BL, `ALU_JIRL: exp_data = pc + 32'd4;
            default:   exp_data = '0;
        endcase
        case (op)
            `ALU_BEQ:  taken = (reg1 == reg2);
            `ALU_BNE:  taken = (reg1 != reg2);
            `ALU_BLT:  taken = ($signed(reg1) < $signed(reg2));
            `ALU_BGE:  taken = ($signed(reg1) >= $signed(reg2));
            `ALU_BLTU: taken = (reg1 < reg2);
            `ALU_BGEU: taken = (reg1 >= reg2);
            default:   taken = is_br;
        endcase
        exp_pc         = pc;
        exp_upd_en     = is_br;
        exp_taken      = is_br && taken;
        exp_redirect   = is_br && ((taken != pre_t) || (taken && pre_a != target));
        exp_addr       = taken ? target : pc + 32'd4;
        exp_addr_valid = is_br && (taken || pre_t);
    endtask

    // **************************************************
    // handshakes
    // **************************************************

    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        while (in_ack !== level && cycles < 200 && !stalled) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (in_ack !== level) report_stall("issue");
    endtask

    task automatic wait_wb_req(input logic level);
        int cycles;
        cycles = 0;
        while (wb_req !== level && cycles < 200 && !stalled) begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (wb_req !== level) report_stall("writeback");
    endtask

    task automatic issue_op(input bus32_t pc, input bus32_t inst, input alu_op_t op,
                            input bus32_t reg1, input bus32_t reg2, input logic pre_t,
                            input bus32_t pre_a);
        in_pc        = pc;
        in_inst      = inst;
        in_aluop     = op;
        in_reg1      = reg1;
        in_reg2      = reg2;
        in_pre_taken = pre_t;
        in_pre_addr  = pre_a;
        in_req       = 1'b1;
        wait_in_ack(1'b1);
        in_req = 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic respond_wb();
        int delay;
        wait_wb_req(1'b1);
        delay = $urandom_range(0, 3);
        repeat (delay) begin
            @(posedge clk);
            #2;
        end
        wb_ack = 1'b1;
        wait_wb_req(1'b0);
        wb_ack = 1'b0;
    endtask

    task automatic run_op(input alu_op_t op, input bus32_t reg1, input bus32_t reg2,
                          input logic pre_t, input logic wrong_addr);
        bus32_t pc;
        bus32_t inst;
        bus32_t pre_a;
        int     off;
        pc = $urandom() & 32'hffff_fffc;
        if (op == `ALU_B || op == `ALU_BL) begin
            off = int'($urandom_range(0, 32'h03ff_ffff)) - 32'sh0200_0000;
        end else begin
            off = int'($urandom_range(0, 32'h0000_ffff)) - 32'sh0000_8000;
        end
        inst  = make_inst(op, off);
        pre_a = pre_t ? branch_target(op, pc, reg1, off) : $urandom();
        if (wrong_addr) pre_a = pre_a ^ 32'h40;
        predict(op, pc, reg1, reg2, pre_t, pre_a, off);
        issue_op(pc, inst, op, reg1, reg2, pre_t, pre_a);
        respond_wb();
    endtask

    // **************************************************
    // stimulus
    // **************************************************

    initial begin : main
        bus32_t a;
        bus32_t b;
        void'($urandom(53));
        clk = 1'b0;
        arst_n = 1'b0;
        in_req = 1'b0;
        in_pc = '0;
        in_inst = '0;
        in_aluop = '0;
        in_reg1 = '0;
        in_reg2 = '0;
        in_pre_taken = 1'b0;
        in_pre_addr = '0;
        wb_ack = 1'b0;
        value_errors = 0;
        protocol_errors = 0;
        stalled = 1'b0;
        predict(8'h00, '0, '0, '0, 1'b0, '0, 0);
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;
        a_reset_idle: assert (in_ack === 1'b0 && wb_req === 1'b0)
            else report_protocol("in_ack or wb_req not low after reset");

        foreach (int_ops[k]) begin
            repeat (4) run_op(int_ops[k], $urandom(), $urandom(), 1'b0, 1'b0);
        end

        // equal, both sign boundaries, random; then three prediction modes
        foreach (cond_ops[k]) begin
            for (int p = 0; p < 4; p++) begin
                case (p)
                    0: begin
                        a = $urandom();
                        b = a;
                    end
                    1: begin
                        a = 32'h8000_0000;
                        b = 32'h7fff_ffff;
                    end
                    2: begin
                        a = 32'h7fff_ffff;
                        b = 32'h8000_0000;
                    end
                    default: begin
                        a = $urandom();
                        b = $urandom();
                    end
                endcase
                for (int m = 0; m < 3; m++) begin
                    run_op(cond_ops[k], a, b, m != 0, m == 2);
                end
            end
        end

        foreach (jump_ops[k]) begin
            for (int m = 0; m < 3; m++) begin
                run_op(jump_ops[k], $urandom(), $urandom(), m != 0, m == 2);
                run_op(jump_ops[k], $urandom(), $urandom(), m != 0, m == 2);
            end
        end

        foreach (unused_ops[k]) begin
            run_op(unused_ops[k], $urandom(), $urandom(), 1'b1, 1'b0);
        end

        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

//--- src.f
+incdir+common
common/pipeline_pkg.sv
common/exe_result_if.sv
branch_alu/branch_alu.sv
src/int_alu.sv
src/exe_commit.sv
src/exe_stage.sv
bench/tb_exe_stage.sv
